/* design/data_port.sv */
`timescale 1ns/1ps

module data_port (
    input  logic                clock,
    input  logic                reset,
    input  logic                load_req,     // One-cycle strobe
    input  logic                store_req,    // One-cycle strobe
    input  mem_pkg::line_addr_t data_addr,
    input  mem_pkg::line_t      store_data,
    output mem_pkg::line_t      load_data,
    output logic                load_valid,
    output logic                busy,
    mem_bus_if.requester        bus
);
    import mem_pkg::*;

    logic       accept;
    logic       write_q;    // Request in flight is a store
    line_addr_t addr_q;
    line_t      wdata_q;

    // Strobes ignored while a request is in flight
    assign accept = !busy && (load_req || store_req);

    assign bus.req   = busy;
    assign bus.write = write_q;
    assign bus.addr  = addr_q;
    assign bus.wdata = wdata_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy       <= 1'b0;
            load_valid <= 1'b0;
        end else begin
            load_valid <= busy && bus.rvalid && !write_q;
            if (accept) begin
                busy <= 1'b1;
            end else if (bus.rvalid) begin
                busy <= 1'b0;       // Done, free next cycle
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            write_q <= store_req;
            addr_q  <= data_addr;
            wdata_q <= store_data;
        end
        if (busy && bus.rvalid && !write_q) begin
            load_data <= bus.rdata;
        end
    end

endmodule

/* design/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     if_valid,         // Fetch enable
    input  logic [isa_pkg::xlen-1:0] branch_pc,        // Resolved branch target
    input  logic                     branch_req,
    input  logic [isa_pkg::xlen-1:0] rob_target_pc,    // Target from ROB retire
    input  logic                     rob_target_req,
    input  logic [isa_pkg::xlen-1:0] pred_pc,          // Predicted target
    input  logic                     pred_req,
    input  logic                     hit,              // Icache has the line
    input  mem_pkg::line_t           line,             // Line holding the PC
    output logic [isa_pkg::xlen-1:0] fetch_addr,
    output isa_pkg::if_id_packet_t   if_packet
);
    import isa_pkg::*;

    logic [xlen-1:0] pc_reg;     // PC being fetched
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] next_pc;
    logic            redirect;   // Any redirect source active
    logic            advance;    // Instruction leaves fetch this cycle
    logic            load_pc;
    inst_t           sel_inst;

    logic            pkt_valid;
    inst_t           pkt_inst;
    logic [xlen-1:0] pkt_pc;
    logic [xlen-1:0] pkt_npc;

    assign pc_plus4 = pc_reg + 4;
    assign redirect = branch_req || rob_target_req || pred_req;
    assign advance  = if_valid && hit;

    // Redirect may land during a miss, the pending fill still completes
    assign load_pc = if_valid && (hit || redirect);

    // Fixed priority, branch over ROB over predictor over sequential
    always_comb begin
        if (branch_req) begin
            next_pc = branch_pc;
        end else if (rob_target_req) begin
            next_pc = rob_target_pc;
        end else if (pred_req) begin
            next_pc = pred_pc;
        end else begin
            next_pc = pc_plus4;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_reg <= '0;
        end else if (load_pc) begin
            pc_reg <= next_pc;
        end
    end

    // Memory lines are 8 bytes, drop the byte offset
    assign fetch_addr = {pc_reg[xlen-1:3], 3'b000};

    // Upper word for PC bit 2 set
    assign sel_inst = pc_reg[2] ? line[63:32] : line[31:0];

    always_ff @(posedge clock) begin
        if (reset) begin
            pkt_valid <= 1'b0;
        end else begin
            pkt_valid <= advance;
        end
    end

    always_ff @(posedge clock) begin
        pkt_inst <= advance ? sel_inst : nop_inst;   // Bubble carries a NOP
        if (advance) begin
            pkt_pc  <= pc_reg;
            pkt_npc <= pc_plus4;
        end
    end

    always_comb begin
        if_packet.valid = pkt_valid;
        if_packet.inst  = pkt_inst;
        if_packet.pc    = pkt_pc;
        if_packet.npc   = pkt_npc;
    end

endmodule

/* design/fetch_subsystem.sv */
`timescale 1ns/1ps

module fetch_subsystem (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     if_valid,
    input  logic [isa_pkg::xlen-1:0] branch_pc,
    input  logic                     branch_req,
    input  logic [isa_pkg::xlen-1:0] rob_target_pc,
    input  logic                     rob_target_req,
    input  logic [isa_pkg::xlen-1:0] pred_pc,
    input  logic                     pred_req,
    input  logic                     load_req,
    input  logic                     store_req,
    input  mem_pkg::line_addr_t      data_addr,
    input  mem_pkg::line_t           store_data,
    output mem_pkg::line_t           load_data,
    output logic                     load_valid,
    output logic                     data_busy,
    output logic                     packet_valid,
    output isa_pkg::inst_t           packet_inst,
    output logic [isa_pkg::xlen-1:0] packet_pc,
    output logic [isa_pkg::xlen-1:0] packet_npc
);
    import isa_pkg::*;
    import mem_pkg::*;

    logic [xlen-1:0] fetch_addr;
    logic            hit;
    line_t           line;
    if_id_packet_t   if_packet;

    mem_bus_if icache_bus ();   // Icache to arbiter
    mem_bus_if data_bus ();     // Data port to arbiter
    mem_bus_if mem_bus ();      // Arbiter to memory

    fetch_stage fetch_stage0 (
        .clock          (clock),
        .reset          (reset),
        .if_valid       (if_valid),
        .branch_pc      (branch_pc),
        .branch_req     (branch_req),
        .rob_target_pc  (rob_target_pc),
        .rob_target_req (rob_target_req),
        .pred_pc        (pred_pc),
        .pred_req       (pred_req),
        .hit            (hit),
        .line           (line),
        .fetch_addr     (fetch_addr),
        .if_packet      (if_packet)
    );

    icache icache0 (
        .clock      (clock),
        .reset      (reset),
        .fetch_addr (fetch_addr),
        .hit        (hit),
        .line       (line),
        .bus        (icache_bus)
    );

    data_port data_port0 (
        .clock      (clock),
        .reset      (reset),
        .load_req   (load_req),
        .store_req  (store_req),
        .data_addr  (data_addr),
        .store_data (store_data),
        .load_data  (load_data),
        .load_valid (load_valid),
        .busy       (data_busy),
        .bus        (data_bus)
    );

    mem_arbiter mem_arbiter0 (
        .clock      (clock),
        .reset      (reset),
        .icache_bus (icache_bus),
        .data_bus   (data_bus),
        .mem_bus    (mem_bus)
    );

    main_memory main_memory0 (
        .clock (clock),
        .reset (reset),
        .bus   (mem_bus)
    );

    // Packet out on plain ports
    assign packet_valid = if_packet.valid;
    assign packet_inst  = if_packet.inst;
    assign packet_pc    = if_packet.pc;
    assign packet_npc   = if_packet.npc;

endmodule

/* design/icache.sv */
`timescale 1ns/1ps

module icache (
    input  logic                     clock,
    input  logic                     reset,
    input  logic [isa_pkg::xlen-1:0] fetch_addr,   // Byte address from fetch
    output logic                     hit,
    output mem_pkg::line_t           line,
    mem_bus_if.requester             bus
);
    import mem_pkg::*;

    line_t                        data_array [icache_lines];
    logic [icache_tag_bits-1:0]   tag_array  [icache_lines];
    logic [icache_lines-1:0]      valid_bits;

    line_addr_t                   line_addr;    // Line holding fetch_addr
    logic [icache_index_bits-1:0] index;
    logic [icache_tag_bits-1:0]   tag;

    logic                         pending;      // Fill outstanding on the bus
    line_addr_t                   miss_addr;    // Held stable while pending
    logic [icache_index_bits-1:0] miss_index;
    logic [icache_tag_bits-1:0]   miss_tag;
    logic                         fill;

    assign line_addr = line_addr_t'(fetch_addr >> 3);
    assign index     = line_addr[icache_index_bits-1:0];
    assign tag       = line_addr[icache_index_bits +: icache_tag_bits];

    // Lookup, combinational from the arrays
    assign hit  = valid_bits[index] && (tag_array[index] == tag);
    assign line = data_array[index];

    assign miss_index = miss_addr[icache_index_bits-1:0];
    assign miss_tag   = miss_addr[icache_index_bits +: icache_tag_bits];
    assign fill       = pending && bus.rvalid;

    // Read-only requester
    assign bus.req   = pending;
    assign bus.write = 1'b0;
    assign bus.addr  = miss_addr;
    assign bus.wdata = '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            pending    <= 1'b0;
            valid_bits <= '0;       // All lines invalid
        end else if (pending) begin
            if (bus.rvalid) begin
                pending               <= 1'b0;
                valid_bits[miss_index] <= 1'b1;   // Hit seen next cycle
            end
        end else if (!hit) begin
            pending <= 1'b1;        // Miss, start a fill
        end
    end

    // Arrays and the miss address
    always_ff @(posedge clock) begin
        if (!pending && !hit) begin
            miss_addr <= line_addr;
        end
        if (fill) begin
            data_array[miss_index] <= bus.rdata;
            tag_array[miss_index]  <= miss_tag;
        end
    end

endmodule

/* design/isa_pkg.sv */
package isa_pkg;

    // Architectural word width
    localparam int xlen = 32;

    // One RV32 instruction word
    typedef logic [31:0] inst_t;

    // addi x0, x0, 0
    localparam inst_t nop_inst = 32'h0000_0013;

    // Packet handed from fetch to decode
    typedef struct packed {
        logic            valid;    // Packet holds a real instruction
        inst_t           inst;     // Fetched instruction
        logic [xlen-1:0] pc;       // Address of inst
        logic [xlen-1:0] npc;      // Sequential successor, pc + 4
    } if_id_packet_t;

endpackage

/* design/main_memory.sv */
`timescale 1ns/1ps

module main_memory (
    input  logic       clock,
    input  logic       reset,
    mem_bus_if.arbiter bus
);
    import mem_pkg::*;

    typedef logic [$clog2(mem_latency)-1:0] count_t;

    line_t      mem_array [mem_depth];
    logic       busy;        // One request at a time
    count_t     count;       // Cycles left before read data
    line_addr_t rd_addr;
    logic       fire_read;   // Read data loads this cycle

    assign bus.gnt   = bus.req && !busy;
    assign fire_read = busy && !bus.rvalid && (count == count_t'(1));

    always_ff @(posedge clock) begin
        if (reset) begin
            busy       <= 1'b0;
            count      <= '0;
            bus.rvalid <= 1'b0;
        end else begin
            bus.rvalid <= 1'b0;
            if (bus.gnt) begin
                busy       <= 1'b1;
                count      <= bus.write ? count_t'(0) : count_t'(mem_latency - 1);
                bus.rvalid <= bus.write;   // Write acknowledged next cycle
            end else if (busy) begin
                if (bus.rvalid) begin
                    busy <= 1'b0;
                end else begin
                    count      <= count - count_t'(1);
                    bus.rvalid <= fire_read;
                end
            end
        end
    end

    // Array writes at the gnt edge, reads land with rvalid
    always_ff @(posedge clock) begin
        if (bus.gnt) begin
            rd_addr <= bus.addr;
            if (bus.write) begin
                mem_array[bus.addr] <= bus.wdata;
            end
        end
        if (fire_read) begin
            bus.rdata <= mem_array[rd_addr];
        end
    end

endmodule

/* design/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter (
    input  logic         clock,
    input  logic         reset,
    mem_bus_if.arbiter   icache_bus,
    mem_bus_if.arbiter   data_bus,
    mem_bus_if.requester mem_bus
);

    logic busy;     // Memory owned by a requester
    logic owner;    // 1 for data port, also last winner once idle
    logic pick;     // Winner if memory grants now
    logic sel;      // Requester routed to memory

    // Round-robin on ties, the loser of last time goes first
    always_comb begin
        if (icache_bus.req && data_bus.req) begin
            pick = ~owner;
        end else begin
            pick = data_bus.req;
        end
    end

    assign sel = busy ? owner : pick;

    // Request side
    assign mem_bus.req   = sel ? data_bus.req   : icache_bus.req;
    assign mem_bus.write = sel ? data_bus.write : icache_bus.write;
    assign mem_bus.addr  = sel ? data_bus.addr  : icache_bus.addr;
    assign mem_bus.wdata = sel ? data_bus.wdata : icache_bus.wdata;

    // Response side, only the owner sees it
    assign icache_bus.gnt    = mem_bus.gnt && !sel;
    assign data_bus.gnt      = mem_bus.gnt && sel;
    assign icache_bus.rvalid = busy && !owner && mem_bus.rvalid;
    assign data_bus.rvalid   = busy && owner && mem_bus.rvalid;
    assign icache_bus.rdata  = (busy && !owner) ? mem_bus.rdata : '0;
    assign data_bus.rdata    = (busy && owner) ? mem_bus.rdata : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            busy  <= 1'b0;
            owner <= 1'b1;          // Icache wins the first tie
        end else if (!busy) begin
            if (mem_bus.gnt) begin
                busy  <= 1'b1;
                owner <= pick;
            end
        end else if (mem_bus.rvalid) begin
            busy <= 1'b0;           // Idle again next cycle
        end
    end

endmodule

/* design/mem_bus_if.sv */
`timescale 1ns/1ps

// One requester's path to memory
interface mem_bus_if;
    import mem_pkg::*;

    logic       req;      // Level, held until rvalid
    logic       write;    // Store when high
    line_addr_t addr;
    line_t      wdata;
    logic       gnt;      // One-cycle pulse when taken
    line_t      rdata;
    logic       rvalid;   // One-cycle pulse, ends the transaction

    modport requester (
        output req, write, addr, wdata,
        input  gnt, rdata, rvalid
    );

    modport arbiter (
        input  req, write, addr, wdata,
        output gnt, rdata, rvalid
    );

endinterface

/* design/mem_pkg.sv */
package mem_pkg;

    // Memory line, two instruction words
    localparam int unsigned line_bits = 64;
    typedef logic [line_bits-1:0] line_t;

    // Main memory geometry and timing
    localparam int unsigned mem_depth   = 256;   // Lines
    localparam int unsigned mem_latency = 3;     // Cycles from gnt to read data

    // Line index into main memory
    typedef logic [$clog2(mem_depth)-1:0] line_addr_t;

    // Direct-mapped icache, index plus tag covers a line address
    localparam int unsigned icache_lines      = 16;
    localparam int unsigned icache_index_bits = 4;
    localparam int unsigned icache_tag_bits   = 4;

endpackage

/* list.f */
design/isa_pkg.sv
design/mem_pkg.sv
design/mem_bus_if.sv
design/fetch_stage.sv
design/icache.sv
design/data_port.sv
design/mem_arbiter.sv
design/main_memory.sv
design/fetch_subsystem.sv
test/tb_fetch_subsystem.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the fetch subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_fetch_subsystem \
    -f list.f \
    -o sim_fetch_subsystem

./obj_dir/sim_fetch_subsystem | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

/* test/tb_fetch_subsystem.sv */
`timescale 1ns/1ps

module tb_fetch_subsystem;
    import isa_pkg::*;
    import mem_pkg::*;

    localparam int timeout_cycles = 400;     // Bound on every wait

    logic            clock;
    logic            reset;
    logic            if_valid;
    logic [xlen-1:0] branch_pc;
    logic            branch_req;
    logic [xlen-1:0] rob_target_pc;
    logic            rob_target_req;
    logic [xlen-1:0] pred_pc;
    logic            pred_req;
    logic            load_req;
    logic            store_req;
    line_addr_t      data_addr;
    line_t           store_data;
    line_t           load_data;
    logic            load_valid;
    logic            data_busy;
    logic            packet_valid;
    inst_t           packet_inst;
    logic [xlen-1:0] packet_pc;
    logic [xlen-1:0] packet_npc;

    line_t           model_mem [mem_depth];  // Memory as written by the stores
    logic [xlen-1:0] exp_pc;                 // Pc of the next packet
    logic [xlen-1:0] pending_target;
    logic            target_pending;         // Redirect taken at the last edge
    logic            if_valid_q = 1'b0;      // Fetch enable one edge back
    logic            timed_out = 1'b0;       // A wait ran out of cycles
    int              packet_count = 0;
    int              seq_errors = 0;         // Main sequence
    int              monitor_errors = 0;     // Packet monitor
    int              property_errors = 0;    // Concurrent properties
    int              tests_passed = 0;
    int              tests_failed = 0;

    fetch_subsystem dut0 (
        .clock          (clock),
        .reset          (reset),
        .if_valid       (if_valid),
        .branch_pc      (branch_pc),
        .branch_req     (branch_req),
        .rob_target_pc  (rob_target_pc),
        .rob_target_req (rob_target_req),
        .pred_pc        (pred_pc),
        .pred_req       (pred_req),
        .load_req       (load_req),
        .store_req      (store_req),
        .data_addr      (data_addr),
        .store_data     (store_data),
        .load_data      (load_data),
        .load_valid     (load_valid),
        .data_busy      (data_busy),
        .packet_valid   (packet_valid),
        .packet_inst    (packet_inst),
        .packet_pc      (packet_pc),
        .packet_npc     (packet_npc)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;   // 4 ns period
        end
    end

    always @(posedge clock) begin
        if_valid_q <= if_valid;
    end

    task automatic report_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout at %0t: %s never happened", $time, what);
        timed_out = 1'b1;
        @(negedge clock);                    // Run ends before this edge
    endtask

    // Ends the run once a wait has timed out
    initial begin
        @(posedge timed_out);
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic int total_errors();
        return seq_errors + monitor_errors + property_errors;
    endfunction

    // Word of the model line picked by pc bit 2
    function automatic inst_t model_inst(input logic [xlen-1:0] pc);
        line_t l;
        l = model_mem[pc[10:3]];
        return pc[2] ? l[63:32] : l[31:0];
    endfunction

    // Branch over ROB over predictor
    function automatic logic [xlen-1:0] priority_target();
        if (branch_req) begin
            return branch_pc;
        end else if (rob_target_req) begin
            return rob_target_pc;
        end
        return pred_pc;
    endfunction

    function automatic logic [xlen-1:0] random_target();
        return $urandom_range(0, 511) << 2;   // Word aligned inside the 2 KB image
    endfunction

    // No packet unless fetch was enabled the cycle before
    assert property (@(posedge clock) disable iff (reset) !if_valid_q |-> !packet_valid)
        else begin
            report_error("packet valid while fetch was disabled");
            property_errors++;
        end

    // Load data lands as the port frees up
    assert property (@(posedge clock) disable iff (reset) load_valid |-> !data_busy)
        else begin
            report_error("load_valid while the data port is still busy");
            property_errors++;
        end

    // Packet monitor samples at the falling edge where outputs and inputs are stable
    always @(negedge clock) begin
        if (reset) begin
            exp_pc = '0;
            target_pending = 1'b0;
        end else begin
            if (packet_valid) begin
                assert (packet_pc == exp_pc) else begin
                    report_error($sformatf("packet pc %h, expected %h", packet_pc, exp_pc));
                    monitor_errors++;
                end
                assert (packet_npc == exp_pc + 32'd4) else begin
                    report_error($sformatf("npc %h at pc %h, expected %h",
                        packet_npc, exp_pc, exp_pc + 32'd4));
                    monitor_errors++;
                end
                assert (packet_inst == model_inst(exp_pc)) else begin
                    report_error($sformatf("inst %h at pc %h, expected %h",
                        packet_inst, exp_pc, model_inst(exp_pc)));
                    monitor_errors++;
                end
                exp_pc = exp_pc + 32'd4;
                packet_count++;
            end
            if (target_pending) begin
                exp_pc = pending_target;     // Packet made at the redirect edge came first
                target_pending = 1'b0;
            end
            if (if_valid && (branch_req || rob_target_req || pred_req)) begin
                pending_target = priority_target();
                target_pending = 1'b1;
            end
        end
    end

    task automatic wait_not_busy(input string what);
        int n;
        n = 0;
        while (data_busy && n < timeout_cycles) begin
            @(negedge clock);
            n++;
        end
        if (data_busy) begin
            timeout_fail(what);
        end
    endtask

    task automatic wait_packets(input int count, input string what);
        int goal;
        int n;
        goal = packet_count + count;
        n = 0;
        while (packet_count < goal && n < timeout_cycles) begin
            @(posedge clock);
            n++;
        end
        if (packet_count < goal) begin
            timeout_fail(what);
        end
    endtask

    task automatic store_line(input line_addr_t addr, input line_t data);
        @(posedge clock);
        store_req  <= 1'b1;
        data_addr  <= addr;
        store_data <= data;
        model_mem[addr] = data;
        @(posedge clock);
        store_req <= 1'b0;
        @(negedge clock);
        assert (data_busy) else begin
            report_error("busy did not rise after a store");
            seq_errors++;
        end
        wait_not_busy("busy falling after a store");
    endtask

    task automatic load_line(input line_addr_t addr);
        int n;
        @(posedge clock);
        load_req  <= 1'b1;
        data_addr <= addr;
        @(posedge clock);
        load_req <= 1'b0;
        n = 0;
        @(negedge clock);
        while (!load_valid && n < timeout_cycles) begin
            @(negedge clock);
            n++;
        end
        if (!load_valid) begin
            timeout_fail("load_valid for a line load");
        end
        assert (load_data == model_mem[addr]) else begin
            report_error($sformatf("load of line %0d gave %h, expected %h",
                addr, load_data, model_mem[addr]));
            seq_errors++;
        end
        wait_not_busy("busy falling after a load");
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (total_errors() == errs_before) begin
            tests_passed++;
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, total_errors() - errs_before);
        end
    endtask

    initial begin
        int         errs;
        logic [2:0] reqs;
        void'($urandom(30));
        reset          = 1'b1;
        if_valid       = 1'b0;
        branch_pc      = '0;
        branch_req     = 1'b0;
        rob_target_pc  = '0;
        rob_target_req = 1'b0;
        pred_pc        = '0;
        pred_req       = 1'b0;
        load_req       = 1'b0;
        store_req      = 1'b0;
        data_addr      = '0;
        store_data     = '0;
        repeat (2) @(posedge clock);
        reset <= 1'b0;

        errs = total_errors();
        repeat (20) begin
            @(negedge clock);
            assert (!packet_valid && !load_valid && !data_busy) else begin
                report_error("output active while idle after reset");
                seq_errors++;
            end
        end
        for (int a = 0; a < mem_depth; a++) begin
            store_line(line_addr_t'(a), {$urandom(), $urandom()});
        end
        finish_test("reset and program load", errs);

        // Reset drops the stale icache line 0 while memory keeps the program
        @(posedge clock);
        reset <= 1'b1;
        repeat (2) @(posedge clock);
        reset <= 1'b0;

        errs = total_errors();
        @(posedge clock);
        if_valid <= 1'b1;
        wait_packets(48, "48 sequential packets from pc 0");
        finish_test("sequential fetch", errs);

        errs = total_errors();
        for (int t = 0; t < 8; t++) begin
            reqs = 3'($urandom_range(3, 7));
            if (reqs == 3'b100) begin
                reqs = 3'b111;                   // Two or more sources at once
            end
            @(posedge clock);
            branch_pc      <= random_target();
            rob_target_pc  <= random_target();
            pred_pc        <= random_target();
            branch_req     <= reqs[2];
            rob_target_req <= reqs[1];
            pred_req       <= reqs[0];
            @(posedge clock);
            branch_req     <= 1'b0;
            rob_target_req <= 1'b0;
            pred_req       <= 1'b0;
            wait_packets(6, "packets after a redirect");
        end
        finish_test("redirect priority", errs);

        errs = total_errors();
        for (int t = 0; t < 4; t++) begin
            wait_packets(3, "packets before fetch was disabled");
            @(posedge clock);
            if_valid <= 1'b0;
            repeat ($urandom_range(3, 12)) @(posedge clock);
            if_valid <= 1'b1;
            wait_packets(3, "packets after fetch was enabled again");
        end
        finish_test("fetch enable gaps", errs);

        errs = total_errors();
        for (int t = 0; t < 12; t++) begin
            load_line(line_addr_t'($urandom_range(0, mem_depth - 1)));   // Competes with fills
        end
        wait_packets(8, "packets after the loads");
        @(posedge clock);
        if_valid <= 1'b0;
        finish_test("loads during fetch", errs);

        $display("Summary: %0d tests passed, %0d failed, %0d errors",
            tests_passed, tests_failed, total_errors());
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
